/* bench/program_cases.txt */
# Case header: <program words> <expected stores>, both decimal
# Then one hex instruction per line, then one "<address> <data>" hex pair per store
15 6
20010007  # addi r1, r0, 7
2002FFFD  # addi r2, r0, -3
00221820  # add  r3, r1, r2
AC030000  # sw   r3, 0(r0)
00222022  # sub  r4, r1, r2
AC040001  # sw   r4, 1(r0)
00222824  # and  r5, r1, r2
AC050002  # sw   r5, 2(r0)
00223025  # or   r6, r1, r2
AC060003  # sw   r6, 3(r0)
0041382A  # slt  r7, r2, r1
AC070004  # sw   r7, 4(r0)
0022402A  # slt  r8, r1, r2
AC080005  # sw   r8, 5(r0)
FC000000  # halt
000 00000004
001 0000000A
002 00000005
003 FFFFFFFF
004 00000001
005 00000000
6 2
20010040  # addi r1, r0, 0x40
20021234  # addi r2, r0, 0x1234
AC220005  # sw   r2, 5(r1)
8C230005  # lw   r3, 5(r1)
AC030010  # sw   r3, 0x10(r0)
FC000000  # halt
045 00001234
010 00001234
7 3
20000055  # addi r0, r0, 0x55
AC000020  # sw   r0, 0x20(r0)
20010009  # addi r1, r0, 9
00210020  # add  r0, r1, r1
AC000021  # sw   r0, 0x21(r0)
AC010022  # sw   r1, 0x22(r0)
FC000000  # halt
020 00000000
021 00000000
022 00000009
12 2
20010001  # addi r1, r0, 1
20020001  # addi r2, r0, 1
10220001  # beq  r1, r2, +1 taken
AC010030  # sw   r1, 0x30(r0) skipped
10200001  # beq  r1, r0, +1 not taken
AC010031  # sw   r1, 0x31(r0)
08000009  # j    9
AC010032  # sw   r1, 0x32(r0) skipped
AC020033  # sw   r2, 0x33(r0) skipped
20030077  # addi r3, r0, 0x77
AC030034  # sw   r3, 0x34(r0)
FC000000  # halt
031 00000001
034 00000077
5 2
AC000040  # sw   r0, 0x40(r0) fetched while run is low
2001005A  # addi r1, r0, 0x5A
AC010041  # sw   r1, 0x41(r0)
FC000000  # halt
AC010042  # sw   r1, 0x42(r0) never reached
040 00000000
041 0000005A

/* list.f */
rtl/CpuPkg.sv
rtl/Alu.sv
rtl/RegisterFile.sv
rtl/Decoder.sv
rtl/Processor.sv
rtl/Memory.sv
rtl/Program.sv
rtl/CpuSystem.sv
bench/CpuSystemTb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the CpuSystem testbench with Verilator and runs it from the project root
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module CpuSystemTb -f list.f -o CpuSystemSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/CpuSystemSim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "NO ERRORS"; then
    exit 0
else
    echo "Pass message not found in the simulation output"
    exit 1
fi

/* bench/CpuSystemTb.sv */
`timescale 1ns/1ns
`default_nettype none

module CpuSystemTb
    import CpuPkg::*;
();

    logic                 clock;
    logic                 rstN;
    logic                 run;
    logic                 pgmWrEnable;
    logic [PcWidth-1:0]   pgmWrAddr;
    logic [InstWidth-1:0] pgmWrInst;
    logic                 memWrEnable;
    logic [AddrWidth-1:0] memAddr;
    logic [DataWidth-1:0] memWrData;
    logic                 halted;

    // Every case is flattened into these queues when the cases file is read
    logic [InstWidth-1:0] pgmWords [$];
    int                   caseWords [$];
    int                   caseStores [$];
    logic [AddrWidth-1:0] expAddrs [$];
    logic [DataWidth-1:0] expDatas [$];
    int                   limitCycles = 0;

    CpuSystem CpuSystem_i (
        .i_Clock       (clock),
        .i_rstN        (rstN),
        .i_Run         (run),
        .i_PgmWrEnable (pgmWrEnable),
        .i_PgmWrAddr   (pgmWrAddr),
        .i_PgmWrInst   (pgmWrInst),
        .o_MemWrEnable (memWrEnable),
        .o_MemAddr     (memAddr),
        .o_MemWrData   (memWrData),
        .o_Halted      (halted));

    // 8 ns clock period
    initial clock = 1'b0;
    always #4 clock = ~clock;

    task automatic stopRun(input string reason);
        $display("%s", reason);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic compareStore(input logic [AddrWidth-1:0] expAddr,
                                input logic [DataWidth-1:0] expData,
                                input logic [AddrWidth-1:0] actAddr,
                                input logic [DataWidth-1:0] actData);
        if (actAddr !== expAddr) begin
            stopRun($sformatf("ERR o_MemAddr expected 0x%h actual 0x%h", expAddr, actAddr));
        end
        if (actData !== expData) begin
            stopRun($sformatf("ERR o_MemWrData expected 0x%h actual 0x%h", expData, actData));
        end
    endtask

    task automatic compareHalt(input int expCount, input int seenCount);
        if (seenCount != expCount) begin
            stopRun($sformatf("ERR store count expected 0x%0h actual 0x%0h",
                expCount, seenCount));
        end
    endtask

    // Inputs change 1 ns after the rising edge, well clear of the flops
    task automatic waitDriveSlot();
        @(posedge clock);
        #1;
    endtask

    // Returns the next line that is neither blank nor a comment
    function automatic int nextDataLine(input int fd, output string line);
        string raw;
        line = "";
        while ($fgets(raw, fd) != 0) begin
            if (raw.len() > 1 && raw.getc(0) != "#") begin
                line = raw;
                return 1;
            end
        end
        return 0;
    endfunction

    task automatic readCases();
        int          fd;
        string       line;
        int          words;
        int          stores;
        logic [31:0] word;
        logic [31:0] addr;
        logic [31:0] data;
        fd = $fopen("bench/program_cases.txt", "r");
        if (fd == 0) begin
            stopRun("Cannot open bench/program_cases.txt for reading");
        end
        while (nextDataLine(fd, line) != 0) begin
            if ($sscanf(line, "%d %d", words, stores) != 2) begin
                stopRun("Malformed case header in the cases file");
            end
            caseWords.push_back(words);
            caseStores.push_back(stores);
            repeat (words) begin
                if (nextDataLine(fd, line) == 0) begin
                    stopRun("The cases file ends inside a program");
                end
                if ($sscanf(line, "%h", word) != 1) begin
                    stopRun("Malformed program word in the cases file");
                end
                pgmWords.push_back(word);
            end
            repeat (stores) begin
                if (nextDataLine(fd, line) == 0) begin
                    stopRun("The cases file ends inside a store list");
                end
                if ($sscanf(line, "%h %h", addr, data) != 2) begin
                    stopRun("Malformed store pair in the cases file");
                end
                expAddrs.push_back(addr[AddrWidth-1:0]);
                expDatas.push_back(data[DataWidth-1:0]);
            end
        end
        $fclose(fd);
    endtask

    // Holds reset for 8 cycles, registers and PC clear but both memories keep their words
    task automatic resetSystem();
        waitDriveSlot();
        run  = 1'b0;
        rstN = 1'b0;
        repeat (8) waitDriveSlot();
        rstN = 1'b1;
    endtask

    task automatic loadProgram(input int first, input int count);
        for (int i = 0; i < count; i++) begin
            waitDriveSlot();
            pgmWrEnable = 1'b1;
            pgmWrAddr   = PcWidth'(i);
            pgmWrInst   = pgmWords[first + i];
        end
        waitDriveSlot();
        pgmWrEnable = 1'b0;
    endtask

    // Outputs are sampled on the falling edge, half a period after any change
    task automatic checkIdle(input int cycles, input logic expHalted, input string phase);
        repeat (cycles) begin
            @(negedge clock);
            if (memWrEnable !== 1'b0) begin
                stopRun($sformatf("A store appeared %s", phase));
            end
            if (halted !== expHalted) begin
                stopRun($sformatf("o_Halted changed %s", phase));
            end
        end
    endtask

    task automatic runCase(input int words, input int firstStore, input int stores);
        int seen;
        int cycles;
        bit done;
        seen   = 0;
        cycles = 0;
        done   = 1'b0;
        waitDriveSlot();
        run = 1'b1;
        while (!done) begin
            @(negedge clock);
            if (halted === 1'b1) begin
                // The first cycle that shows the halt must already be free of stores
                if (memWrEnable !== 1'b0) begin
                    stopRun("A store appeared in the first cycle after HALT");
                end
                done = 1'b1;
            end else begin
                if (memWrEnable === 1'b1) begin
                    if (seen >= stores) begin
                        stopRun("A store appeared after all expected stores were seen");
                    end
                    compareStore(expAddrs[firstStore + seen], expDatas[firstStore + seen],
                        memAddr, memWrData);
                    seen++;
                end
                cycles++;
                if (cycles > 64 * words) begin
                    stopRun("The program never reached its HALT");
                end
            end
        end
        compareHalt(stores, seen);
        // Still running, so the halt alone must keep the core quiet
        checkIdle(8, 1'b1, "after HALT");
        waitDriveSlot();
        run = 1'b0;
    endtask

    initial begin
        int wordBase;
        int storeBase;
        int total;
        rstN        = 1'b0;
        run         = 1'b0;
        pgmWrEnable = 1'b0;
        pgmWrAddr   = '0;
        pgmWrInst   = '0;
        wordBase    = 0;
        storeBase   = 0;
        total       = 0;
        readCases();
        if (caseWords.size() == 0) begin
            stopRun("The cases file holds no test case");
        end
        foreach (caseWords[c]) begin
            total += caseWords[c];
        end
        limitCycles = 64 * total;
        foreach (caseWords[c]) begin
            resetSystem();
            loadProgram(wordBase, caseWords[c]);
            // The first word may be a store, so nothing may happen until run rises
            checkIdle(8, 1'b0, "while run was low");
            runCase(caseWords[c], storeBase, caseStores[c]);
            wordBase  += caseWords[c];
            storeBase += caseStores[c];
        end
        $display("NO ERRORS");
        $finish;
    end

    // Budget of 64 cycles per program word, summed over all cases
    initial begin
        wait (limitCycles > 0);
        repeat (limitCycles) @(posedge clock);
        stopRun($sformatf("Timeout after %0d cycles", limitCycles));
    end

endmodule

`default_nettype wire

/* rtl/CpuSystem.sv */
`timescale 1ns/1ns
`default_nettype none

module CpuSystem
    import CpuPkg::*;
(
    input  logic                 i_Clock,
    input  logic                 i_rstN,
    input  logic                 i_Run,
    input  logic                 i_PgmWrEnable,
    input  logic [PcWidth-1:0]   i_PgmWrAddr,
    input  logic [InstWidth-1:0] i_PgmWrInst,
    output logic                 o_MemWrEnable,
    output logic [AddrWidth-1:0] o_MemAddr,
    output logic [DataWidth-1:0] o_MemWrData,
    output logic                 o_Halted
);

    logic [PcWidth-1:0]   PgmAddr;
    logic [InstWidth-1:0] PgmInst;
    logic [DataWidth-1:0] MemRdData;

    // Data RAM shares its write signals with the observation outputs
    Memory Memory_i (
        .i_Clock    (i_Clock),
        .i_Addr     (o_MemAddr),
        .i_WrEnable (o_MemWrEnable),
        .i_WrData   (o_MemWrData),
        .o_RdData   (MemRdData));

    // Program store is filled through the load port while the core is stopped
    Program Program_i (
        .i_Clock    (i_Clock),
        .i_Addr     (PgmAddr),
        .o_Inst     (PgmInst),
        .i_WrEnable (i_PgmWrEnable),
        .i_WrAddr   (i_PgmWrAddr),
        .i_WrInst   (i_PgmWrInst));

    Processor Processor_i (
        .i_Clock       (i_Clock),
        .i_rstN        (i_rstN),
        .i_Run         (i_Run),
        .o_PgmAddr     (PgmAddr),
        .i_PgmInst     (PgmInst),
        .o_MemAddr     (o_MemAddr),
        .o_MemWrEnable (o_MemWrEnable),
        .o_MemWrData   (o_MemWrData),
        .i_MemRdData   (MemRdData),
        .o_Halted      (o_Halted));

endmodule

`default_nettype wire

/* rtl/Program.sv */
`timescale 1ns/1ns
`default_nettype none

module Program
    import CpuPkg::*;
(
    input  logic                 i_Clock,
    input  logic [PcWidth-1:0]   i_Addr,
    output logic [InstWidth-1:0] o_Inst,
    input  logic                 i_WrEnable,
    input  logic [PcWidth-1:0]   i_WrAddr,
    input  logic [InstWidth-1:0] i_WrInst
);

    logic [InstWidth-1:0] Insts [2**PcWidth];

    // Unloaded words read as zero, which the decoder treats as a no-op
    initial begin
        for (int i = 0; i < 2**PcWidth; i++) begin
            Insts[i] = '0;
        end
    end

    // The load port writes one word per strobed cycle
    always_ff @(posedge i_Clock) begin
        if (i_WrEnable) begin
            Insts[i_WrAddr] <= i_WrInst;
        end
    end

    // Fetch is combinational so the core decodes in the same cycle
    assign o_Inst = Insts[i_Addr];

endmodule

`default_nettype wire

/* rtl/Memory.sv */
`timescale 1ns/1ns
`default_nettype none

module Memory
    import CpuPkg::*;
(
    input  logic                 i_Clock,
    input  logic [AddrWidth-1:0] i_Addr,
    input  logic                 i_WrEnable,
    input  logic [DataWidth-1:0] i_WrData,
    output logic [DataWidth-1:0] o_RdData
);

    // One word per address, the whole RAM is 2**AddrWidth words deep
    logic [DataWidth-1:0] Words [2**AddrWidth];

    // Simulation and FPGA power-up both start with an all-zero RAM
    initial begin
        for (int i = 0; i < 2**AddrWidth; i++) begin
            Words[i] = '0;
        end
    end

    // Writes take effect at the next rising edge
    always_ff @(posedge i_Clock) begin
        if (i_WrEnable) begin
            Words[i_Addr] <= i_WrData;
        end
    end

    // Loads see the word within the same cycle
    assign o_RdData = Words[i_Addr];

endmodule

`default_nettype wire

/* rtl/Processor.sv */
`timescale 1ns/1ns
`default_nettype none

module Processor
    import CpuPkg::*;
(
    input  logic                 i_Clock,
    input  logic                 i_rstN,
    input  logic                 i_Run,
    output logic [PcWidth-1:0]   o_PgmAddr,
    input  logic [InstWidth-1:0] i_PgmInst,
    output logic [AddrWidth-1:0] o_MemAddr,
    output logic                 o_MemWrEnable,
    output logic [DataWidth-1:0] o_MemWrData,
    input  logic [DataWidth-1:0] i_MemRdData,
    output logic                 o_Halted
);

    logic [PcWidth-1:0]   Pc;
    logic [PcWidth-1:0]   PcPlus1;
    logic [PcWidth-1:0]   NextPc;
    logic                 Halted;
    logic                 Step;

    AluOp                 DecAluOp;
    logic                 AluSrcImm;
    logic                 RegWrite;
    logic                 RegDstRd;
    logic                 MemToReg;
    logic                 MemWrite;
    logic                 Branch;
    logic                 Jump;
    logic                 Halt;

    logic [RegWidth-1:0]  WrReg;
    logic [DataWidth-1:0] WrData;
    logic [DataWidth-1:0] RsData;
    logic [DataWidth-1:0] RtData;
    logic [DataWidth-1:0] Imm;
    logic [DataWidth-1:0] AluB;
    logic [DataWidth-1:0] AluResult;
    logic                 AluZero;

    // The core advances only when allowed to run and not yet halted
    assign Step = i_Run && !Halted;

    Decoder Decoder_i (
        .i_Inst      (i_PgmInst),
        .o_AluOp     (DecAluOp),
        .o_AluSrcImm (AluSrcImm),
        .o_RegWrite  (RegWrite),
        .o_RegDstRd  (RegDstRd),
        .o_MemToReg  (MemToReg),
        .o_MemWrite  (MemWrite),
        .o_Branch    (Branch),
        .o_Jump      (Jump),
        .o_Halt      (Halt));

    // R-type writes rd, immediate forms write rt
    assign WrReg  = RegDstRd ? i_PgmInst[15:11] : i_PgmInst[20:16];
    assign WrData = MemToReg ? i_MemRdData : AluResult;

    // Register writes are held off while the core is stopped
    RegisterFile RegisterFile_i (
        .i_Clock    (i_Clock),
        .i_rstN     (i_rstN),
        .i_RdAddrA  (i_PgmInst[25:21]),
        .i_RdAddrB  (i_PgmInst[20:16]),
        .o_RdDataA  (RsData),
        .o_RdDataB  (RtData),
        .i_WrEnable (RegWrite && Step),
        .i_WrAddr   (WrReg),
        .i_WrData   (WrData));

    // Sign-extended 16-bit immediate feeds both the ALU and the branch offset
    assign Imm  = {{(DataWidth-16){i_PgmInst[15]}}, i_PgmInst[15:0]};
    assign AluB = AluSrcImm ? Imm : RtData;

    Alu Alu_i (
        .i_Op     (DecAluOp),
        .i_A      (RsData),
        .i_B      (AluB),
        .o_Result (AluResult),
        .o_Zero   (AluZero));

    // Branch offsets and jump targets are both counted in words
    assign PcPlus1 = Pc + 1'b1;

    always_comb begin
        if (Jump) begin
            NextPc = i_PgmInst[PcWidth-1:0];
        end else if (Branch && AluZero) begin
            NextPc = PcPlus1 + Imm[PcWidth-1:0];
        end else begin
            NextPc = PcPlus1;
        end
    end

    // A HALT sets the flag and leaves the PC frozen until the next reset
    always_ff @(posedge i_Clock or negedge i_rstN) begin
        if (!i_rstN) begin
            Pc     <= '0;
            Halted <= 1'b0;
        end else if (Step) begin
            if (Halt) begin
                Halted <= 1'b1;
            end else begin
                Pc <= NextPc;
            end
        end
    end

    assign o_PgmAddr = Pc;

    // Stores land at the edge that ends the SW cycle
    assign o_MemAddr     = AluResult[AddrWidth-1:0];
    assign o_MemWrEnable = MemWrite && Step;
    assign o_MemWrData   = RtData;
    assign o_Halted      = Halted;

endmodule

`default_nettype wire

/* rtl/Decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module Decoder
    import CpuPkg::*;
(
    input  logic [InstWidth-1:0] i_Inst,
    output AluOp                 o_AluOp,
    output logic                 o_AluSrcImm,
    output logic                 o_RegWrite,
    output logic                 o_RegDstRd,
    output logic                 o_MemToReg,
    output logic                 o_MemWrite,
    output logic                 o_Branch,
    output logic                 o_Jump,
    output logic                 o_Halt
);

    Opcode InstOp;
    Funct  InstFunct;

    // Only the opcode and the function field steer the control signals
    assign InstOp    = Opcode'(i_Inst[31:26]);
    assign InstFunct = Funct'(i_Inst[5:0]);

    always_comb begin
        // Defaults describe a no-op that only advances the PC
        o_AluOp     = AluAdd;
        o_AluSrcImm = 1'b0;
        o_RegWrite  = 1'b0;
        o_RegDstRd  = 1'b0;
        o_MemToReg  = 1'b0;
        o_MemWrite  = 1'b0;
        o_Branch    = 1'b0;
        o_Jump      = 1'b0;
        o_Halt      = 1'b0;
        case (InstOp)
            OpRType: begin
                // R-type results go to rd, an unknown function writes nothing
                o_RegDstRd = 1'b1;
                o_RegWrite = 1'b1;
                case (InstFunct)
                    FnAdd:   o_AluOp = AluAdd;
                    FnSub:   o_AluOp = AluSub;
                    FnAnd:   o_AluOp = AluAnd;
                    FnOr:    o_AluOp = AluOr;
                    FnSlt:   o_AluOp = AluSlt;
                    default: o_RegWrite = 1'b0;
                endcase
            end
            OpAddi: begin
                o_AluSrcImm = 1'b1;
                o_RegWrite  = 1'b1;
            end
            OpLw: begin
                // Address is rs plus the immediate, the loaded word goes to rt
                o_AluSrcImm = 1'b1;
                o_RegWrite  = 1'b1;
                o_MemToReg  = 1'b1;
            end
            OpSw: begin
                o_AluSrcImm = 1'b1;
                o_MemWrite  = 1'b1;
            end
            OpBeq: begin
                // The ALU subtracts and its zero flag decides the branch
                o_AluOp  = AluSub;
                o_Branch = 1'b1;
            end
            OpJ: begin
                o_Jump = 1'b1;
            end
            OpHalt: begin
                o_Halt = 1'b1;
            end
            default: begin
                // Unknown opcodes keep the no-op defaults
            end
        endcase
    end

endmodule

`default_nettype wire

/* rtl/RegisterFile.sv */
`timescale 1ns/1ns
`default_nettype none

module RegisterFile
    import CpuPkg::*;
(
    input  logic                 i_Clock,
    input  logic                 i_rstN,
    input  logic [RegWidth-1:0]  i_RdAddrA,
    input  logic [RegWidth-1:0]  i_RdAddrB,
    output logic [DataWidth-1:0] o_RdDataA,
    output logic [DataWidth-1:0] o_RdDataB,
    input  logic                 i_WrEnable,
    input  logic [RegWidth-1:0]  i_WrAddr,
    input  logic [DataWidth-1:0] i_WrData
);

    // Register zero has no storage, only registers 1 to 31 exist
    logic [DataWidth-1:0] Regs [1:(2**RegWidth)-1];

    // All writable registers start from zero after reset
    always_ff @(posedge i_Clock or negedge i_rstN) begin
        if (!i_rstN) begin
            for (int i = 1; i < 2**RegWidth; i++) begin
                Regs[i] <= '0;
            end
        end else if (i_WrEnable && (i_WrAddr != '0)) begin
            Regs[i_WrAddr] <= i_WrData;
        end
    end

    // Reads are combinational and register zero is hardwired to zero
    assign o_RdDataA = (i_RdAddrA == '0) ? '0 : Regs[i_RdAddrA];
    assign o_RdDataB = (i_RdAddrB == '0) ? '0 : Regs[i_RdAddrB];

endmodule

`default_nettype wire

/* rtl/Alu.sv */
`timescale 1ns/1ns
`default_nettype none

module Alu
    import CpuPkg::*;
(
    input  AluOp                 i_Op,
    input  logic [DataWidth-1:0] i_A,
    input  logic [DataWidth-1:0] i_B,
    output logic [DataWidth-1:0] o_Result,
    output logic                 o_Zero
);

    // The whole unit is combinational and settles within the cycle
    always_comb begin
        case (i_Op)
            AluAdd: begin
                o_Result = i_A + i_B;
            end
            AluSub: begin
                // Also used by BEQ to compare the two register operands
                o_Result = i_A - i_B;
            end
            AluAnd: begin
                o_Result = i_A & i_B;
            end
            AluOr: begin
                o_Result = i_A | i_B;
            end
            AluSlt: begin
                // Signed compare so that negative operands order correctly
                if ($signed(i_A) < $signed(i_B)) begin
                    o_Result = {{(DataWidth-1){1'b0}}, 1'b1};
                end else begin
                    o_Result = '0;
                end
            end
            default: begin
                o_Result = '0;
            end
        endcase
    end

    // A zero result after subtraction means the operands were equal
    assign o_Zero = (o_Result == '0);

endmodule

`default_nettype wire

/* rtl/CpuPkg.sv */
`default_nettype none

package CpuPkg;

    // Width of the datapath, the registers and each data-RAM word
    localparam int DataWidth = 32;

    // The data RAM is addressed in words, 1024 of them
    localparam int AddrWidth = 10;

    // The program store is also addressed in words
    localparam int PcWidth = 10;

    // Five bits select one of the 32 registers
    localparam int RegWidth = 5;

    // Every instruction word is 32 bits, independent of the data width
    localparam int InstWidth = 32;

    // Primary opcode in bits 31 to 26 of the instruction
    // The HALT code sits in a slot that MIPS leaves unused
    typedef enum logic [5:0] {
        OpRType = 6'h00,
        OpJ     = 6'h02,
        OpBeq   = 6'h04,
        OpAddi  = 6'h08,
        OpLw    = 6'h23,
        OpSw    = 6'h2B,
        OpHalt  = 6'h3F
    } Opcode;

    // Function field of R-type instructions in bits 5 to 0
    typedef enum logic [5:0] {
        FnAdd = 6'h20,
        FnSub = 6'h22,
        FnAnd = 6'h24,
        FnOr  = 6'h25,
        FnSlt = 6'h2A
    } Funct;

    // Operation selected for the ALU by the decoder
    typedef enum logic [2:0] {
        AluAdd,
        AluSub,
        AluAnd,
        AluOr,
        AluSlt
    } AluOp;

endpackage

`default_nettype wire
